//--- vlog.f
source/dbg_pkg.sv
source/dbg_cmd_decode.sv
source/dbg_burst_ctrl.sv
source/dbg_bus_master.sv
source/dbg_crc32.sv
source/dbg_tdo_result.sv
source/dbg_wb_module.sv
dv/tb_clk_gen.sv
dv/dbg_wb_module_sva.sv
dv/tb_dbg_wb_module.sv

//--- Makefile
# Verilator build and run for the debug module testbench

VERILATOR ?= verilator
TOP       ?= tb_dbg_wb_module
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= vlog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_dbg_wb_module.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_wb_module
  import dbg_pkg::*;
();

  localparam int     NUM_ENTRIES  = 6;
  localparam int     ENTRY_CYCLES = 600;  // Worst write plus read-back of one entry
  localparam int     POLL_MAX     = 16;
  localparam longint WATCHDOG_NS  = longint'(NUM_ENTRIES * ENTRY_CYCLES + 8) * 40;

  logic                 tck;
  logic                 rst;
  logic                 tdi;
  logic                 capture_dr;
  logic                 shift_dr;
  logic                 update_dr;
  logic                 module_select;
  logic [DR_WIDTH-1:0]  data_register;
  logic [DR_WIDTH-1:0]  dr_q;               // Host copy of the TAP DR
  wire                  module_tdo;
  wire                  top_inhibit;
  wire  [31:0]          bus_adr;
  wire  [31:0]          bus_dat_o;
  logic [31:0]          bus_dat_i = '0;
  wire                  bus_stb;
  wire                  bus_we;
  wire  [3:0]           bus_sel;
  logic                 bus_ack   = 1'b0;
  logic [1:0]           ack_wait  = '0;
  logic [31:0]          rng_state = 32'h8edc3eba;
  logic [31:0]          mem     [256];      // Bus memory, word indexed
  logic [31:0]          exp_mem [256];
  logic [31:0]          xfer_adr[$];        // Bus transfer log
  logic [3:0]           xfer_sel[$];
  logic                 xfer_we [$];
  dbg_op_e              tbl_op   [NUM_ENTRIES];
  logic [31:0]          tbl_addr [NUM_ENTRIES];
  logic [15:0]          tbl_count[NUM_ENTRIES];
  logic [31:0]          tbl_seed [NUM_ENTRIES];
  logic                 tbl_bad  [NUM_ENTRIES];  // Send a wrong CRC
  logic                 tbl_match[NUM_ENTRIES];  // Expected match bit
  int                   errors = 0;
  int                   checks = 0;

  tb_clk_gen u_clk (.tck_o(tck), .rst_o(rst));

  dbg_wb_module u_dut (
    .tck_i(tck), .rst_i(rst), .tdi_i(tdi), .capture_dr_i(capture_dr),
    .shift_dr_i(shift_dr), .update_dr_i(update_dr), .module_select_i(module_select),
    .data_register_i(data_register), .module_tdo_o(module_tdo),
    .top_inhibit_o(top_inhibit), .bus_adr_o(bus_adr), .bus_dat_o(bus_dat_o),
    .bus_dat_i(bus_dat_i), .bus_stb_o(bus_stb), .bus_we_o(bus_we),
    .bus_sel_o(bus_sel), .bus_ack_i(bus_ack)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {~idx, idx, idx ^ 8'h3c, idx + 8'h71};  // Unique per word address
  endfunction

  // One input bit through the reflected CRC-32
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic b);
    return (c >> 1) ^ ((c[0] ^ b) ? CRC_POLY : 32'h0);
  endfunction

  ////////////////////
  // Bus memory, ack after 1 to 3 cycles
  always @(posedge tck) begin
    bus_ack <= 1'b0;
    if (rst) begin
      for (int i = 0; i < 256; i++) mem[i] = fill_word(8'(i));
      ack_wait <= '0;
    end else if (bus_stb && !bus_ack) begin
      if (ack_wait != 2'd0) begin
        ack_wait <= ack_wait - 2'd1;
      end else begin
        bus_ack <= 1'b1;
        if (bus_we) begin
          for (int k = 0; k < 4; k++) begin
            if (bus_sel[k]) mem[bus_adr[9:2]][8*k +: 8] = bus_dat_o[8*k +: 8];
          end
        end else begin
          bus_dat_i <= mem[bus_adr[9:2]];
        end
        xfer_adr.push_back(bus_adr);
        xfer_sel.push_back(bus_sel);
        xfer_we.push_back(bus_we);
        rng_state = xorshift32(rng_state);
        ack_wait <= 2'(rng_state % 32'd3);
      end
    end
  end

  ////////////////////
  // Host TAP model
  task automatic tap_cycle(input logic cap, input logic sh, input logic upd, input logic b);
    @(posedge tck);
    if (shift_dr) dr_q = {tdi, dr_q[DR_MSB:1]};  // Bit shifted in on this edge
    if (cap) dr_q = '0;
    data_register <= dr_q;
    tdi           <= b;
    capture_dr    <= cap;
    shift_dr      <= sh;
    update_dr     <= upd;
  endtask

  task automatic tap_shift(input logic b, output logic tdo);
    tap_cycle(1'b0, 1'b1, 1'b0, b);
    @(negedge tck);
    tdo = module_tdo;
  endtask

  task automatic tap_command(input dbg_op_e op, input logic [31:0] addr,
                             input logic [15:0] count);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    dr_q = {1'b0, op, addr, count};
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic tap_close();
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0);
    tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge tck);
  endtask

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic add_entry(input int e, input dbg_op_e op, input logic [31:0] addr,
                           input logic [15:0] count, input logic [31:0] seed,
                           input logic bad);
    tbl_op[e]    = op;
    tbl_addr[e]  = addr;
    tbl_count[e] = count;
    tbl_seed[e]  = seed;
    tbl_bad[e]   = bad;
    tbl_match[e] = ~bad;
  endtask

  // Addresses and lanes of the transfers logged since base
  task automatic check_transfers(input int e, input int base, input int bytes,
                                 input logic we);
    logic [31:0] a;
    logic [3:0]  sel;
    int          n;
    n = int'(tbl_count[e]);
    checks++;
    if (xfer_adr.size() - base != n) begin
      flag_mismatch($sformatf("entry %0d saw %0d bus cycles, expected %0d",
                              e, xfer_adr.size() - base, n));
    end else begin
      for (int i = 0; i < n; i++) begin
        a   = tbl_addr[e] + 32'(i * bytes);
        sel = '0;
        for (int k = 0; k < bytes; k++) sel[int'(a[1:0]) + k] = 1'b1;
        checks++;
        if (xfer_adr[base+i] != a || xfer_sel[base+i] != sel || xfer_we[base+i] != we) begin
          flag_mismatch($sformatf("entry %0d cycle %0d adr %h sel %b we %b, expected %h %b %b",
                        e, i, xfer_adr[base+i], xfer_sel[base+i], xfer_we[base+i], a, sel, we));
        end
      end
    end
  endtask

  task automatic run_entry(input int e);
    dbg_op_e     rd_op;
    logic [31:0] words[$];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] crc;
    logic [31:0] got;
    logic        tdo;
    int          bytes;
    int          bits;
    int          n;
    int          base;
    int          polls;
    rd_op = dbg_op_e'(4'(tbl_op[e]) + 4'd4);
    bytes = (tbl_op[e] == bwrite8) ? 1 : (tbl_op[e] == bwrite16) ? 2 : 4;
    bits  = 8 * bytes;
    n     = int'(tbl_count[e]);
    base  = xfer_adr.size();
    w     = tbl_seed[e];
    for (int i = 0; i < n; i++) begin
      w = xorshift32(w);
      words.push_back((bits == 32) ? w : w & ((32'd1 << bits) - 32'd1));
    end
    if (n == 0) begin
      tap_command(tbl_op[e], tbl_addr[e], 16'd0);
      repeat (4) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      tap_command(rd_op, tbl_addr[e], 16'd0);
      repeat (4) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0);
      @(negedge tck);
      checks++;
      if (xfer_adr.size() != base) flag_mismatch("bus cycle issued for a zero count");
      checks++;
      if (top_inhibit !== 1'b0) flag_mismatch("inhibit still high after a zero count");
      return;
    end
    ////////////////////
    // Burst write, start bit then data LSB first
    tap_command(tbl_op[e], tbl_addr[e], tbl_count[e]);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    tap_shift(1'b1, tdo);
    crc = CRC_INIT;
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < bits; b++) begin
        tap_shift(words[i][b], tdo);
        crc = crc_step(crc, words[i][b]);
      end
      a = tbl_addr[e] + 32'(i * bytes);
      for (int k = 0; k < bytes; k++) begin
        exp_mem[a[9:2]][8 * (int'(a[1:0]) + k) +: 8] = words[i][8*k +: 8];
      end
    end
    if (tbl_bad[e]) crc = crc ^ 32'h0000_0100;
    for (int b = 0; b < 32; b++) tap_shift(crc[b], tdo);
    tap_shift(1'b0, tdo);  // Match bit shows once all 32 CRC bits are in
    checks++;
    if (tdo !== tbl_match[e]) begin
      flag_mismatch($sformatf("entry %0d match bit %b, expected %b", e, tdo, tbl_match[e]));
    end
    checks++;
    if (top_inhibit !== 1'b1) flag_mismatch("inhibit low during the write burst");
    tap_close();
    checks++;
    if (top_inhibit !== 1'b0) flag_mismatch("inhibit high after the write closed");
    check_transfers(e, base, bytes, 1'b1);
    for (int i = 0; i < 256; i++) begin
      checks++;
      if (mem[i] !== exp_mem[i]) begin
        flag_mismatch($sformatf("memory word %0d is %h, expected %h", i, mem[i], exp_mem[i]));
      end
    end
    ////////////////////
    // Read back, poll the status bit first
    base = xfer_adr.size();
    tap_command(rd_op, tbl_addr[e], tbl_count[e]);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0);
    tdo   = 1'b0;
    polls = 0;
    while (!tdo && polls < POLL_MAX) begin
      tap_shift(1'b0, tdo);
      polls++;
    end
    if (!tdo) begin
      errors++;
      $display("Entry %0d: read status bit never went high", e);
      tap_close();
      return;
    end
    checks++;
    if (top_inhibit !== 1'b1) flag_mismatch("inhibit low during the read burst");
    crc = CRC_INIT;
    for (int i = 0; i < n; i++) begin
      got = '0;
      for (int b = 0; b < bits; b++) begin
        tap_shift(1'b0, tdo);
        got[b] = tdo;
        crc    = crc_step(crc, words[i][b]);
      end
      checks++;
      if (got !== words[i]) begin
        flag_mismatch($sformatf("entry %0d read word %0d is %h, expected %h",
                                e, i, got, words[i]));
      end
    end
    for (int b = 0; b < 32; b++) begin
      tap_shift(1'b0, tdo);
      got[b] = tdo;
    end
    checks++;
    if (got !== crc) flag_mismatch($sformatf("entry %0d read CRC %h, expected %h", e, got, crc));
    tap_close();
    check_transfers(e, base, bytes, 1'b0);
  endtask

  initial begin : main
    tdi           = 1'b0;
    capture_dr    = 1'b0;
    shift_dr      = 1'b0;
    update_dr     = 1'b0;
    module_select = 1'b1;
    data_register = '0;
    dr_q          = '0;
    for (int i = 0; i < 256; i++) exp_mem[i] = fill_word(8'(i));
    add_entry(0, bwrite32, 32'h0000_0100, 16'd4, 32'h1234_5678, 1'b0);
    add_entry(1, bwrite8,  32'h0000_0203, 16'd6, 32'h0bad_cafe, 1'b0);
    add_entry(2, bwrite16, 32'h0000_0302, 16'd3, 32'h5eed_0002, 1'b0);
    add_entry(3, bwrite32, 32'h0000_0040, 16'd2, 32'h7777_1111, 1'b1);
    add_entry(4, bwrite16, 32'h0000_0080, 16'd0, 32'h0000_0001, 1'b0);
    add_entry(5, bwrite8,  32'h0000_0011, 16'd3, 32'h2468_ace0, 1'b0);
    @(negedge rst);
    @(negedge tck);
    checks++;
    if (bus_stb !== 1'b0 || top_inhibit !== 1'b0) begin
      flag_mismatch("strobe or inhibit not low after reset");
    end
    for (int e = 0; e < NUM_ENTRIES; e++) run_entry(e);
    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Hard stop if a handshake never completes
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, simulation hung", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/dbg_wb_module_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_wb_module_sva (
  input wire        tck_i,
  input wire        rst_i,
  input wire        bus_stb_i,
  input wire        bus_ack_i,
  input wire [31:0] bus_adr_i,
  input wire        top_inhibit_i,
  input wire        bus_strobe_i,  // Request from the control FSM
  input wire        bus_rdy_i      // Bus master idle
);

  ////////////////////
  // Bus handshake
  stb_hold_a: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_stb_i && !bus_ack_i |=> bus_stb_i)
    else $error("bus strobe dropped before its ack");

  adr_stable_a: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_stb_i && !bus_ack_i |=> $stable(bus_adr_i))
    else $error("bus address moved while strobe was pending");

  // New request only to an idle master
  no_busy_strobe_a: assert property (@(posedge tck_i) disable iff (rst_i)
    bus_strobe_i |-> bus_rdy_i)
    else $error("bus request issued while the master was busy");

  ////////////////////
  // Quiet right after reset
  reset_quiet_a: assert property (@(posedge tck_i)
    $fell(rst_i) |=> !bus_stb_i && !top_inhibit_i)
    else $error("strobe or inhibit high just after reset");

endmodule

bind dbg_wb_module dbg_wb_module_sva u_sva (
  .tck_i        (tck_i),
  .rst_i        (rst_i),
  .bus_stb_i    (bus_stb_o),
  .bus_ack_i    (bus_ack_i),
  .bus_adr_i    (bus_adr_o),
  .top_inhibit_i(top_inhibit_o),
  .bus_strobe_i (bus_strobe),
  .bus_rdy_i    (bus_rdy)
);

`default_nettype wire

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic tck_o,
  output logic rst_o
);

  localparam int HALF_PERIOD  = 20;  // 40 ns TCK
  localparam int RESET_CYCLES = 8;

  initial begin
    tck_o = 1'b0;
    forever #(HALF_PERIOD) tck_o = ~tck_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge tck_o);
    rst_o <= 1'b0;  // Released on an edge, seen from the next one
  end

endmodule

`default_nettype wire

//--- source/dbg_wb_module.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_wb_module
  import dbg_pkg::*;
(
  // TAP side
  input  wire                  tck_i,
  input  wire                  rst_i,
  input  wire                  tdi_i,
  input  wire                  capture_dr_i,
  input  wire                  shift_dr_i,
  input  wire                  update_dr_i,
  input  wire                  module_select_i,
  input  wire [DR_WIDTH-1:0]   data_register_i,
  output logic                 module_tdo_o,
  output logic                 top_inhibit_o,
  // Bus side
  output logic [BUS_WIDTH-1:0] bus_adr_o,
  output logic [BUS_WIDTH-1:0] bus_dat_o,
  input  wire  [BUS_WIDTH-1:0] bus_dat_i,
  output logic                 bus_stb_o,
  output logic                 bus_we_o,
  output logic [3:0]           bus_sel_o,
  input  wire                  bus_ack_i
);

  logic                 burst_cmd;
  logic                 burst_rd;
  logic                 rd_op;
  bit_cnt_t             word_bits;
  logic [2:0]           word_bytes;
  logic                 op_ld;
  logic [BUS_WIDTH-1:0] bus_addr;
  logic                 bus_strobe;
  logic                 bus_rdy;
  logic [BUS_WIDTH-1:0] rd_data;
  logic [BUS_WIDTH-1:0] wr_word;
  logic                 out_ld;
  logic                 out_shift_en;
  logic                 crc_clr;
  logic                 crc_en;
  logic                 crc_in_tdi;
  logic                 crc_shift;
  tdo_sel_e             tdo_sel;

  // tdi is one bit ahead of the DR, so it completes the serial word
  assign wr_word = {tdi_i, data_register_i[DR_MSB -: BUS_WIDTH-1]};

  ////////////////////
  // Decode
  dbg_cmd_decode u_decode (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .data_register_i(data_register_i),
    .op_ld_i        (op_ld),
    .burst_cmd_o    (burst_cmd),
    .burst_rd_o     (burst_rd),
    .rd_op_o        (rd_op),
    .word_bits_o    (word_bits),
    .word_bytes_o   (word_bytes)
  );

  ////////////////////
  // Execute
  dbg_burst_ctrl u_ctrl (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .module_select_i(module_select_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .data_register_i(data_register_i),
    .burst_cmd_i    (burst_cmd),
    .burst_rd_i     (burst_rd),
    .word_bits_i    (word_bits),
    .word_bytes_i   (word_bytes),
    .bus_rdy_i      (bus_rdy),
    .op_ld_o        (op_ld),
    .bus_addr_o     (bus_addr),
    .bus_strobe_o   (bus_strobe),
    .out_ld_o       (out_ld),
    .out_shift_en_o (out_shift_en),
    .crc_clr_o      (crc_clr),
    .crc_en_o       (crc_en),
    .crc_in_tdi_o   (crc_in_tdi),
    .crc_shift_o    (crc_shift),
    .tdo_sel_o      (tdo_sel),
    .top_inhibit_o  (top_inhibit_o)
  );

  dbg_bus_master u_bus (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .strobe_i    (bus_strobe),
    .addr_i      (bus_addr),
    .wr_word_i   (wr_word),
    .rd_wrn_i    (rd_op),
    .word_bytes_i(word_bytes),
    .bus_dat_i   (bus_dat_i),
    .bus_ack_i   (bus_ack_i),
    .rd_data_o   (rd_data),
    .rdy_o       (bus_rdy),
    .bus_adr_o   (bus_adr_o),
    .bus_dat_o   (bus_dat_o),
    .bus_stb_o   (bus_stb_o),
    .bus_we_o    (bus_we_o),
    .bus_sel_o   (bus_sel_o)
  );

  ////////////////////
  // Result
  dbg_tdo_result u_result (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .data_register_i(data_register_i),
    .rd_data_i      (rd_data),
    .bus_rdy_i      (bus_rdy),
    .out_ld_i       (out_ld),
    .out_shift_en_i (out_shift_en),
    .crc_clr_i      (crc_clr),
    .crc_en_i       (crc_en),
    .crc_in_tdi_i   (crc_in_tdi),
    .crc_shift_i    (crc_shift),
    .tdo_sel_i      (tdo_sel),
    .module_tdo_o   (module_tdo_o)
  );

endmodule

`default_nettype wire

//--- source/dbg_tdo_result.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_tdo_result
  import dbg_pkg::*;
(
  input  wire                 tck_i,
  input  wire                 rst_i,
  input  wire                 tdi_i,
  input  wire [DR_WIDTH-1:0]  data_register_i,
  input  wire [BUS_WIDTH-1:0] rd_data_i,
  input  wire                 bus_rdy_i,
  input  wire                 out_ld_i,
  input  wire                 out_shift_en_i,
  input  wire                 crc_clr_i,
  input  wire                 crc_en_i,
  input  wire                 crc_in_tdi_i,
  input  wire                 crc_shift_i,
  input  wire tdo_sel_e       tdo_sel_i,
  output logic                module_tdo_o
);

  logic [BUS_WIDTH-1:0] out_q;      // Read word on its way out
  logic                 crc_din;
  logic [CRC_WIDTH-1:0] crc_val;
  logic                 crc_ser;
  logic                 crc_match;  // Received CRC equals ours

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_q <= '0;
    end else if (out_ld_i) begin
      out_q <= rd_data_i;  // Load wins over shift on the last bit
    end else if (out_shift_en_i) begin
      out_q <= out_q >> 1;
    end
  end

  assign crc_din = crc_in_tdi_i ? tdi_i : out_q[0];  // Write data or outgoing read data

  dbg_crc32 u_crc (
    .tck_i   (tck_i),
    .rst_i   (rst_i),
    .data_i  (crc_din),
    .enable_i(crc_en_i),
    .shift_i (crc_shift_i),
    .clr_i   (crc_clr_i),
    .crc_o   (crc_val),
    .serial_o(crc_ser)
  );

  // Host CRC arrives LSB first, so it ends up in the top DR bits
  assign crc_match = (data_register_i[DR_MSB -: CRC_WIDTH] == crc_val);

  ////////////////////
  // TDO source
  always_comb begin
    case (tdo_sel_i)
      status:  module_tdo_o = bus_rdy_i;
      data:    module_tdo_o = out_q[0];
      match:   module_tdo_o = crc_match;
      default: module_tdo_o = crc_ser;
    endcase
  end

endmodule

`default_nettype wire

//--- source/dbg_crc32.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_crc32
  import dbg_pkg::*;
(
  input  wire                  tck_i,
  input  wire                  rst_i,
  input  wire                  data_i,
  input  wire                  enable_i,  // Fold data_i in
  input  wire                  shift_i,   // Shift the result out
  input  wire                  clr_i,
  output logic [CRC_WIDTH-1:0] crc_o,
  output logic                 serial_o
);

  logic fb;  // Feedback bit

  assign fb       = crc_o[0] ^ data_i;
  assign serial_o = crc_o[0];  // LSB first

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_o <= CRC_INIT;
    end else if (clr_i) begin
      crc_o <= CRC_INIT;
    end else if (enable_i) begin
      crc_o <= (crc_o >> 1) ^ (fb ? CRC_POLY : '0);  // No final inversion
    end else if (shift_i) begin
      crc_o <= crc_o >> 1;
    end
  end

endmodule

`default_nettype wire

//--- source/dbg_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_bus_master
  import dbg_pkg::*;
(
  input  wire                  tck_i,
  input  wire                  rst_i,
  input  wire                  strobe_i,      // One-cycle request
  input  wire [BUS_WIDTH-1:0]  addr_i,
  input  wire [BUS_WIDTH-1:0]  wr_word_i,     // Valid bits at the top
  input  wire                  rd_wrn_i,
  input  wire [2:0]            word_bytes_i,
  input  wire [BUS_WIDTH-1:0]  bus_dat_i,
  input  wire                  bus_ack_i,
  output logic [BUS_WIDTH-1:0] rd_data_o,     // Right aligned
  output logic                 rdy_o,
  output logic [BUS_WIDTH-1:0] bus_adr_o,
  output logic [BUS_WIDTH-1:0] bus_dat_o,
  output logic                 bus_stb_o,
  output logic                 bus_we_o,
  output logic [3:0]           bus_sel_o
);

  logic [BUS_WIDTH-1:0] wr_aligned;  // Write word moved down to bit 0
  logic [3:0]           sel_base;    // Lanes before the address offset
  logic [4:0]           lane_shift;  // Bit offset of the addressed lane
  logic [2:0]           bytes_q;     // Size of the transfer in flight
  logic [BUS_WIDTH-1:0] rd_shifted;
  logic [BUS_WIDTH-1:0] rd_word;

  assign lane_shift = {addr_i[1:0], 3'b000};
  assign rdy_o      = ~bus_stb_o;

  // Request size to lanes
  always_comb begin
    case (word_bytes_i)
      3'd1: begin
        wr_aligned = BUS_WIDTH'(wr_word_i[BUS_WIDTH-1 -: 8]);
        sel_base   = 4'b0001;
      end
      3'd2: begin
        wr_aligned = BUS_WIDTH'(wr_word_i[BUS_WIDTH-1 -: 16]);
        sel_base   = 4'b0011;
      end
      default: begin
        wr_aligned = wr_word_i;
        sel_base   = 4'b1111;
      end
    endcase
  end

  // Pull the addressed lanes down to bit 0
  assign rd_shifted = bus_dat_i >> {bus_adr_o[1:0], 3'b000};

  always_comb begin
    case (bytes_q)
      3'd1:    rd_word = BUS_WIDTH'(rd_shifted[7:0]);
      3'd2:    rd_word = BUS_WIDTH'(rd_shifted[15:0]);
      default: rd_word = rd_shifted;
    endcase
  end

  ////////////////////
  // Strobe held until ack
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bus_stb_o <= 1'b0;
      bus_we_o  <= 1'b0;
    end else if (strobe_i) begin
      bus_stb_o <= 1'b1;
      bus_we_o  <= ~rd_wrn_i;
    end else if (bus_ack_i) begin
      bus_stb_o <= 1'b0;
    end
  end

  always_ff @(posedge tck_i) begin
    if (strobe_i) begin
      bus_adr_o <= addr_i;
      bus_dat_o <= wr_aligned << lane_shift;
      bus_sel_o <= sel_base << addr_i[1:0];
      bytes_q   <= word_bytes_i;
    end
    if (bus_stb_o && bus_ack_i && !bus_we_o) begin
      rd_data_o <= rd_word;  // Read data captured on ack
    end
  end

endmodule

`default_nettype wire

//--- source/dbg_burst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_burst_ctrl
  import dbg_pkg::*;
(
  input  wire                  tck_i,
  input  wire                  rst_i,
  input  wire                  module_select_i,
  input  wire                  capture_dr_i,
  input  wire                  shift_dr_i,
  input  wire                  update_dr_i,
  input  wire [DR_WIDTH-1:0]   data_register_i,
  input  wire                  burst_cmd_i,
  input  wire                  burst_rd_i,
  input  wire bit_cnt_t        word_bits_i,
  input  wire [2:0]            word_bytes_i,
  input  wire                  bus_rdy_i,
  output logic                 op_ld_o,         // Also loads the counters
  output logic [BUS_WIDTH-1:0] bus_addr_o,      // Address of the next transfer
  output logic                 bus_strobe_o,
  output logic                 out_ld_o,
  output logic                 out_shift_en_o,
  output logic                 crc_clr_o,
  output logic                 crc_en_o,
  output logic                 crc_in_tdi_o,    // Write data into the CRC, else read data
  output logic                 crc_shift_o,
  output tdo_sel_e             tdo_sel_o,
  output logic                 top_inhibit_o
);

  dbg_state_e state_q;
  dbg_state_e state_d;
  bit_cnt_t   bit_cnt_q;   // Bits of the current word
  word_cnt_t  word_cnt_q;  // Words not yet handled
  logic       shift_en;    // Our DR is shifting this cycle
  logic       bit_clr;
  logic       bit_inc;
  logic       word_dec;
  logic       bit_last;
  logic       bit_32;
  logic       word_zero;
  logic       word_one;

  assign shift_en  = module_select_i & shift_dr_i;
  assign bit_last  = (bit_cnt_q == word_bits_i - 6'd1);  // Last bit of a word
  assign bit_32    = (bit_cnt_q == 6'd32);               // Whole write CRC is in the DR
  assign word_zero = (word_cnt_q == '0);
  assign word_one  = (word_cnt_q == word_cnt_t'(1));

  assign crc_clr_o     = op_ld_o;  // Every new burst restarts the CRC
  assign top_inhibit_o = !(state_q inside {idle, rd_begin, wr_ready});

  ////////////////////
  // State and counters
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= idle;
      bit_cnt_q  <= '0;
      word_cnt_q <= '0;
      bus_addr_o <= '0;
    end else begin
      state_q <= state_d;
      if (bit_clr) begin
        bit_cnt_q <= '0;
      end else if (bit_inc) begin
        bit_cnt_q <= bit_cnt_q + 6'd1;
      end
      if (op_ld_o) begin
        word_cnt_q <= data_register_i[COUNT_WIDTH-1:0];
        bus_addr_o <= data_register_i[ADDR_LSB +: BUS_WIDTH];
      end else begin
        if (word_dec) begin
          word_cnt_q <= word_cnt_q - word_cnt_t'(1);
        end
        if (bus_strobe_o) begin
          bus_addr_o <= bus_addr_o + BUS_WIDTH'(word_bytes_i);  // Step by word size
        end
      end
    end
  end

  ////////////////////
  // Next state and strobes
  always_comb begin
    state_d        = state_q;
    op_ld_o        = 1'b0;
    bit_clr        = 1'b0;
    bit_inc        = 1'b0;
    word_dec       = 1'b0;
    bus_strobe_o   = 1'b0;
    out_ld_o       = 1'b0;
    out_shift_en_o = 1'b0;
    crc_en_o       = 1'b0;
    crc_in_tdi_o   = 1'b0;
    crc_shift_o    = 1'b0;
    tdo_sel_o      = data;
    if (state_q != idle && update_dr_i) begin
      state_d = idle;  // Host closed the transfer
    end else begin
      case (state_q)
        idle: begin
          if (module_select_i && update_dr_i && burst_cmd_i) begin
            op_ld_o = 1'b1;
            bit_clr = 1'b1;
            state_d = burst_rd_i ? rd_begin : wr_ready;
          end
        end
        rd_begin: begin
          if (word_zero) begin
            state_d = idle;  // Empty burst, no bus cycle
          end else begin
            bus_strobe_o = 1'b1;  // Fetch the first word early
            state_d      = rd_ready;
          end
        end
        rd_ready: begin
          if (module_select_i && capture_dr_i) begin
            state_d = rd_status;
          end
        end
        rd_status: begin
          tdo_sel_o = status;  // Host polls for the ready bit
          if (shift_en && bus_rdy_i) begin
            out_ld_o     = 1'b1;
            bit_clr      = 1'b1;
            word_dec     = 1'b1;
            bus_strobe_o = !word_one;  // Prefetch while words remain
            state_d      = rd_burst;
          end
        end
        rd_burst: begin
          if (shift_en) begin
            out_shift_en_o = 1'b1;
            bit_inc        = 1'b1;
            crc_en_o       = 1'b1;  // CRC sees the bit leaving on TDO
            if (bit_last) begin
              bit_clr = 1'b1;
              if (word_zero) begin
                state_d = rd_crc;
              end else begin
                out_ld_o     = 1'b1;
                word_dec     = 1'b1;
                bus_strobe_o = !word_one;
              end
            end
          end
        end
        rd_crc: begin
          tdo_sel_o   = crc;
          crc_shift_o = shift_en;  // Runs until update
        end
        wr_ready: begin
          if (word_zero) begin
            state_d = idle;
          end else if (module_select_i && capture_dr_i) begin
            state_d = wr_wait;
          end
        end
        wr_wait: begin
          if (shift_en && data_register_i[DR_MSB]) begin
            bit_inc      = 1'b1;  // Start bit seen, tdi already holds bit 0
            crc_en_o     = 1'b1;
            crc_in_tdi_o = 1'b1;
            state_d      = wr_burst;
          end
        end
        wr_burst: begin
          if (shift_en) begin
            bit_inc      = 1'b1;
            crc_en_o     = 1'b1;
            crc_in_tdi_o = 1'b1;
            if (bit_last) begin
              bit_clr      = 1'b1;
              bus_strobe_o = 1'b1;  // Word complete on tdi and DR
              word_dec     = 1'b1;
              if (word_one) begin
                state_d = wr_crc;
              end
            end
          end
        end
        wr_crc: begin
          tdo_sel_o = bit_32 ? match : data;
          if (shift_en) begin
            bit_inc = 1'b1;
            if (bit_32) begin
              state_d = wr_match;
            end
          end
        end
        wr_match: tdo_sel_o = match;  // Held until update
        default: state_d = idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/dbg_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_decode
  import dbg_pkg::*;
(
  input  wire                tck_i,
  input  wire                rst_i,
  input  wire [DR_WIDTH-1:0] data_register_i,
  input  wire                op_ld_i,       // Command accepted, keep its opcode
  output logic               burst_cmd_o,   // Legal burst command in the register
  output logic               burst_rd_o,    // ... and it is a read
  output logic               rd_op_o,       // Latched burst is a read
  output bit_cnt_t           word_bits_o,   // 8, 16 or 32
  output logic [2:0]         word_bytes_o   // 1, 2 or 4
);

  dbg_op_e op_in;  // Opcode field as it stands
  dbg_op_e op_q;   // Opcode of the running burst

  assign op_in = dbg_op_e'(data_register_i[OP_LSB +: 4]);

  // Bit 52 low marks a command for this module
  assign burst_cmd_o = ~data_register_i[DR_MSB] &
                       (op_in inside {bwrite8, bwrite16, bwrite32, bread8, bread16, bread32});
  assign burst_rd_o  = op_in inside {bread8, bread16, bread32};

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      op_q <= nop;
    end else if (op_ld_i) begin
      op_q <= op_in;
    end
  end

  ////////////////////
  // Size and direction of the latched burst
  always_comb begin
    word_bits_o  = 6'd8;  // Byte wide unless told otherwise
    word_bytes_o = 3'd1;
    case (op_q)
      bwrite16, bread16: begin
        word_bits_o  = 6'd16;
        word_bytes_o = 3'd2;
      end
      bwrite32, bread32: begin
        word_bits_o  = 6'd32;
        word_bytes_o = 3'd4;
      end
      default: ;
    endcase
    rd_op_o = op_q inside {bread8, bread16, bread32};
  end

endmodule

`default_nettype wire

//--- source/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

  ////////////////////
  // Data register layout
  localparam int DR_WIDTH    = 53;  // Full JTAG data register
  localparam int DR_MSB      = 52;  // Command flag, also the write start bit
  localparam int OP_LSB      = 48;  // Opcode sits in [51:48]
  localparam int ADDR_LSB    = 16;  // Start address sits in [47:16]
  localparam int COUNT_WIDTH = 16;  // Word count sits in [15:0]

  ////////////////////
  // Bus and CRC
  localparam int BUS_WIDTH = 32;
  localparam int CRC_WIDTH = 32;
  localparam logic [CRC_WIDTH-1:0] CRC_INIT = '1;            // All ones
  localparam logic [CRC_WIDTH-1:0] CRC_POLY = 32'hEDB8_8320;  // Reflected Ethernet

  typedef logic [5:0]             bit_cnt_t;   // Room for 32 plus the CRC tail
  typedef logic [COUNT_WIDTH-1:0] word_cnt_t;

  // Burst opcodes, bit 2 set for reads
  typedef enum logic [3:0] {
    nop      = 4'd0,
    bwrite8  = 4'd1,
    bwrite16 = 4'd2,
    bwrite32 = 4'd3,
    bread8   = 4'd5,
    bread16  = 4'd6,
    bread32  = 4'd7
  } dbg_op_e;

  typedef enum logic [3:0] {
    idle, rd_begin, rd_ready, rd_status, rd_burst, rd_crc,
    wr_ready, wr_wait, wr_burst, wr_crc, wr_match
  } dbg_state_e;

  // What goes out on TDO
  typedef enum logic [1:0] {
    status,  // Bus ready flag
    data,    // Output shift register LSB
    match,   // Write CRC compare
    crc      // Own CRC, shifted out
  } tdo_sel_e;

endpackage

`default_nettype wire
